// File: cdc_fifo.f
cdc_fifo_pkg.sv
cdc_fifo_ram_if.sv
gray_pointer_sync.sv
cdc_fifo_write_side.sv
cdc_fifo_ram.sv
cdc_fifo_read_side.sv
cdc_fifo.sv
cdc_fifo_tb.sv

// File: cdc_fifo.sv
/*
 * Dual-clock stream FIFO, top level.
 * Moves data words from the rx_aclk domain to the tx_aclk domain with
 * valid/ready handshakes on both sides.
 */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo (
    input logic areset_n,
    // Rx stream.
    input logic rx_aclk,
    input logic rx_tvalid,
    input cdc_fifo_pkg::data_t rx_tdata,
    output logic rx_tready,
    // Tx stream.
    input logic tx_aclk,
    input logic tx_tready,
    output logic tx_tvalid,
    output cdc_fifo_pkg::data_t tx_tdata
);
    import cdc_fifo_pkg::*;

    // Gray pointers in their own domain and after crossing.
    pointer_t write_pointer_gray;
    pointer_t write_pointer_gray_synced;
    pointer_t read_pointer_gray;
    pointer_t read_pointer_gray_synced;

    cdc_fifo_ram_if ram_if ();

    cdc_fifo_write_side write_side_i (
        .areset_n(areset_n),
        .rx_aclk(rx_aclk),
        .rx_tvalid(rx_tvalid),
        .rx_tdata(rx_tdata),
        .rx_tready(rx_tready),
        .ram(ram_if.writer),
        .write_pointer_gray(write_pointer_gray),
        .read_pointer_gray(read_pointer_gray_synced)
    );

    cdc_fifo_ram ram_i (
        .rx_aclk(rx_aclk),
        .tx_aclk(tx_aclk),
        .port(ram_if.ram)
    );

    cdc_fifo_read_side read_side_i (
        .areset_n(areset_n),
        .tx_aclk(tx_aclk),
        .tx_tready(tx_tready),
        .tx_tvalid(tx_tvalid),
        .tx_tdata(tx_tdata),
        .ram(ram_if.reader),
        .read_pointer_gray(read_pointer_gray),
        .write_pointer_gray(write_pointer_gray_synced)
    );

    // Write pointer into the tx domain.
    gray_pointer_sync write_pointer_sync_i (
        .areset_n(areset_n),
        .clk(tx_aclk),
        .pointer(write_pointer_gray),
        .pointer_synced(write_pointer_gray_synced)
    );

    // Read pointer into the rx domain.
    gray_pointer_sync read_pointer_sync_i (
        .areset_n(areset_n),
        .clk(rx_aclk),
        .pointer(read_pointer_gray),
        .pointer_synced(read_pointer_gray_synced)
    );
endmodule

`default_nettype wire

// File: cdc_fifo_pkg.sv
/*
 * Dual-clock stream FIFO shared definitions.
 * Holds the word and RAM sizes, the vector types built from them and the
 * Gray code helpers used by both clock domains.
 */
`default_nettype none

package cdc_fifo_pkg;
    // One stream word.
    localparam int DATA_WIDTH = 16;
    localparam int ADDRESS_WIDTH = 4;
    localparam int CAPACITY = 2 ** ADDRESS_WIDTH;

    // The fill level at which the input side stops accepting beats.
    localparam int ALMOST_FULL = CAPACITY - 3;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    // The extra top bit tells a full FIFO from an empty one.
    typedef logic [ADDRESS_WIDTH:0] pointer_t;

    function automatic pointer_t binary_to_gray(input pointer_t binary);
        return binary ^ (binary >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at or above it.
    function automatic pointer_t gray_to_binary(input pointer_t gray);
        pointer_t binary;
        binary[ADDRESS_WIDTH] = gray[ADDRESS_WIDTH];
        for (int i = ADDRESS_WIDTH - 1; i >= 0; i--) begin
            binary[i] = binary[i + 1] ^ gray[i];
        end
        return binary;
    endfunction
endpackage

`default_nettype wire

// File: cdc_fifo_ram.sv
/*
 * Dual-clock FIFO storage.
 * A simple dual-port array written on rx_aclk and read into a registered
 * output on tx_aclk, in the manner of a block RAM without show-ahead.
 */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_ram (
    input logic rx_aclk,
    input logic tx_aclk,
    cdc_fifo_ram_if.ram port
);
    import cdc_fifo_pkg::*;

    data_t memory [CAPACITY];

    // Write port.
    // The write side guarantees that the location has already been read.
    always_ff @(posedge rx_aclk) begin
        if (port.write_enable) begin
            memory[port.write_address] <= port.write_data;
        end
    end

    // Read port.
    // The output register holds its word until the next read, which keeps
    // tx_tdata stable while the consumer stalls.
    always_ff @(posedge tx_aclk) begin
        if (port.read_enable) begin
            port.read_data <= memory[port.read_address];
        end
    end
endmodule

`default_nettype wire

// File: cdc_fifo_ram_if.sv
/*
 * RAM port bundle of the dual-clock FIFO.
 * The write port belongs to the rx domain and the read port to the tx
 * domain; no clock travels with it.
 */
`timescale 1ns/1ps
`default_nettype none

interface cdc_fifo_ram_if;
    import cdc_fifo_pkg::*;

    // Write port, driven from the rx domain.
    logic write_enable;
    address_t write_address;
    data_t write_data;

    // Read port, addressed from the tx domain.
    logic read_enable;
    address_t read_address;

    // Registered read result from the RAM.
    data_t read_data;

    modport writer (
        output write_enable,
        output write_address,
        output write_data
    );

    modport reader (
        output read_enable,
        output read_address,
        input read_data
    );

    modport ram (
        input write_enable,
        input write_address,
        input write_data,
        input read_enable,
        input read_address,
        output read_data
    );
endinterface

`default_nettype wire

// File: cdc_fifo_read_side.sv
/*
 * Dual-clock FIFO output side, tx_aclk domain.
 * Keeps the read pointer, detects empty against the synchronized write
 * pointer and runs the idle/data machine that presents words on tx.
 */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_read_side (
    input logic areset_n,
    input logic tx_aclk,
    input logic tx_tready,
    output logic tx_tvalid,
    output cdc_fifo_pkg::data_t tx_tdata,
    cdc_fifo_ram_if.reader ram,
    output cdc_fifo_pkg::pointer_t read_pointer_gray,
    input cdc_fifo_pkg::pointer_t write_pointer_gray
);
    import cdc_fifo_pkg::*;

    // IDLE: nothing is on the output.
    // DATA: the RAM output register holds a word not yet taken.
    typedef enum logic [0:0] {
        STATE_IDLE,
        STATE_DATA
    } state_t;

    state_t state;

    pointer_t read_pointer;
    pointer_t read_pointer_next;
    pointer_t write_pointer;
    logic empty;
    logic read_enable;

    // The synchronized write pointer trails the real one.
    // Empty may be reported late, but never while the RAM holds nothing.
    always_comb write_pointer = gray_to_binary(write_pointer_gray);
    always_comb empty = (read_pointer == write_pointer);

    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= STATE_IDLE;
        end
        else begin
            unique case (state)
                STATE_IDLE: begin
                    if (!empty) begin
                        state <= STATE_DATA;
                    end
                end
                STATE_DATA: begin
                    if (tx_tready && empty) begin
                        state <= STATE_IDLE;
                    end
                end
                default: begin
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

    // In idle the output register is free, so any stored word is fetched.
    // In data a new word is fetched only as the current one is taken.
    always_comb begin
        unique case (state)
            STATE_IDLE: read_enable = !empty;
            STATE_DATA: read_enable = !empty && tx_tready;
            default: read_enable = 1'b0;
        endcase
    end

    always_comb read_pointer_next = read_pointer + pointer_t'(1);

    // Every issued read frees one location.
    // The Gray copy goes back to the write side.
    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            read_pointer <= '0;
            read_pointer_gray <= '0;
        end
        else if (read_enable) begin
            read_pointer <= read_pointer_next;
            read_pointer_gray <= binary_to_gray(read_pointer_next);
        end
    end

    always_comb begin
        ram.read_enable = read_enable;
        ram.read_address = read_pointer[ADDRESS_WIDTH-1:0];
    end

    // The word appears on the edge that enters data, so valid and data
    // line up without an extra stage.
    always_comb tx_tvalid = (state == STATE_DATA);
    always_comb tx_tdata = ram.read_data;
endmodule

`default_nettype wire

// File: cdc_fifo_tb.sv
/*
 * Testbench for the dual-clock stream FIFO.
 * Random rx beats and random tx back-pressure on drifting clocks, with every
 * word checked against a queue model of the stream.
 */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_tb;
    import cdc_fifo_pkg::*;

    localparam int BEAT_COUNT = 2000;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT_CYCLES = 40 * BEAT_COUNT;
    // Every HOLD_INTERVAL tx cycles the consumer stalls for HOLD_CYCLES.
    localparam int HOLD_INTERVAL = 400;
    localparam int HOLD_CYCLES = 60;
    localparam int DRAIN_CYCLES = 60;

    logic areset_n;
    logic rx_aclk;
    logic rx_tvalid;
    data_t rx_tdata;
    logic rx_tready;
    logic tx_aclk;
    logic tx_tready;
    logic tx_tvalid;
    data_t tx_tdata;

    int seed;
    int cycle_count;
    logic rx_done;

    // Words accepted on rx and not yet taken on tx, oldest first.
    data_t model [$];

    // Output state seen at the previous tx sample.
    logic stalled;
    data_t held_data;

    cdc_fifo dut_i (
        .areset_n(areset_n),
        .rx_aclk(rx_aclk),
        .rx_tvalid(rx_tvalid),
        .rx_tdata(rx_tdata),
        .rx_tready(rx_tready),
        .tx_aclk(tx_aclk),
        .tx_tready(tx_tready),
        .tx_tvalid(tx_tvalid),
        .tx_tdata(tx_tdata)
    );

    always #50 rx_aclk = ~rx_aclk;

    // The tx clock starts high, so its falling edges never meet those of rx.
    always #65 tx_aclk = ~tx_aclk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                $time, name, actual, expected));
        end
    endtask

    function automatic int random_percent();
        int unsigned value;
        value = $random(seed);
        return value % 100;
    endfunction

    // The DUT outputs only move on rising edges.
    // What is seen on a falling edge is what the next rising edge acts on.
    task automatic send_beats();
        int sent;
        logic pending;
        sent = 0;
        pending = 1'b0;
        while (sent < BEAT_COUNT) begin
            @(negedge rx_aclk);
            // An offered beat stays on the bus until it is taken.
            if (!pending) begin
                rx_tvalid = (random_percent() < 70);
                rx_tdata = data_t'($random(seed));
            end
            if (rx_tvalid && rx_tready) begin
                model.push_back(rx_tdata);
                sent++;
                pending = 1'b0;
                if (model.size() > CAPACITY) begin
                    abort_run("The FIFO accepted more words than it can hold.");
                end
            end
            else begin
                pending = rx_tvalid;
            end
        end
        @(negedge rx_aclk);
        rx_tvalid = 1'b0;
        rx_done = 1'b1;
    endtask

    task automatic tx_step(input int ready_percent, input logic expect_idle);
        data_t expected;
        @(negedge tx_aclk);
        if (expect_idle) begin
            check_flag("tx_tvalid", tx_tvalid, 1'b0);
        end
        // A stalled word stays on the output until it is taken.
        if (stalled) begin
            check_flag("tx_tvalid", tx_tvalid, 1'b1);
            check_data("tx_tdata", tx_tdata, held_data);
        end
        tx_tready = (random_percent() < ready_percent);
        if (tx_tvalid && tx_tready) begin
            if (model.size() == 0) begin
                abort_run("A word left the FIFO that was never sent.");
            end
            expected = model.pop_front();
            check_data("tx_tdata", tx_tdata, expected);
        end
        stalled = tx_tvalid && !tx_tready;
        held_data = tx_tdata;
    endtask

    task automatic receive_beats();
        int tx_cycle;
        logic hold;
        tx_cycle = 0;
        while (!rx_done) begin
            hold = (tx_cycle % HOLD_INTERVAL) >= (HOLD_INTERVAL - HOLD_CYCLES);
            tx_step(hold ? 0 : 70, 1'b0);
            tx_cycle++;
        end
        // Drain with the consumer always ready.
        // Once the model is empty the output must stay idle.
        repeat (DRAIN_CYCLES) begin
            tx_step(100, model.size() == 0);
        end
        if (model.size() != 0) begin
            abort_run("Words were still missing when the drain period ended.");
        end
    endtask

    always @(posedge rx_aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run("Timeout: the run did not finish in the expected number of cycles.");
        end
    end

    initial begin
        seed = 3770;
        cycle_count = 0;
        rx_done = 1'b0;
        stalled = 1'b0;
        held_data = '0;
        rx_aclk = 1'b0;
        tx_aclk = 1'b1;
        areset_n = 1'b0;
        rx_tvalid = 1'b0;
        rx_tdata = '0;
        tx_tready = 1'b0;

        repeat (RESET_CYCLES) begin
            @(negedge rx_aclk);
            check_flag("rx_tready", rx_tready, 1'b0);
            check_flag("tx_tvalid", tx_tvalid, 1'b0);
        end
        areset_n = 1'b1;
        // Both flags are registered, so the release alone must not raise them.
        // These are the values the first rising edge after reset sees.
        #1;
        check_flag("rx_tready", rx_tready, 1'b0);
        check_flag("tx_tvalid", tx_tvalid, 1'b0);

        fork
            send_beats();
            receive_beats();
        join

        $display("Result: PASSED");
        $finish;
    end
endmodule

`default_nettype wire

// File: cdc_fifo_write_side.sv
/*
 * Dual-clock FIFO input side, rx_aclk domain.
 * Captures accepted beats, writes them to the RAM one cycle later, keeps
 * the write pointer and withdraws rx_tready when the FIFO is almost full.
 */
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_write_side (
    input logic areset_n,
    input logic rx_aclk,
    input logic rx_tvalid,
    input cdc_fifo_pkg::data_t rx_tdata,
    output logic rx_tready,
    cdc_fifo_ram_if.writer ram,
    output cdc_fifo_pkg::pointer_t write_pointer_gray,
    input cdc_fifo_pkg::pointer_t read_pointer_gray
);
    import cdc_fifo_pkg::*;

    logic write_enable;
    data_t write_data;

    pointer_t write_pointer;
    pointer_t write_pointer_next;
    pointer_t read_pointer;
    pointer_t fill_level;
    logic almost_full;

    // The write strobe marks a beat accepted on the previous edge.
    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            write_enable <= 1'b0;
        end
        else begin
            write_enable <= rx_tvalid && rx_tready;
        end
    end

    // Payload register, qualified by write_enable.
    always_ff @(posedge rx_aclk) begin
        write_data <= rx_tdata;
    end

    always_comb write_pointer_next = write_pointer + pointer_t'(1);

    // The pointer moves on the same edge that commits the word to the RAM.
    // The Gray copy is registered so that it leaves the domain glitch free.
    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            write_pointer <= '0;
            write_pointer_gray <= '0;
        end
        else if (write_enable) begin
            write_pointer <= write_pointer_next;
            write_pointer_gray <= binary_to_gray(write_pointer_next);
        end
    end

    // The low pointer bits address the RAM.
    always_comb begin
        ram.write_enable = write_enable;
        ram.write_address = write_pointer[ADDRESS_WIDTH-1:0];
        ram.write_data = write_data;
    end

    // The synchronized read pointer is a few cycles old.
    // The level computed from it can only be too high, never too low.
    always_comb read_pointer = gray_to_binary(read_pointer_gray);
    always_comb fill_level = write_pointer - read_pointer;
    always_comb almost_full = (fill_level >= pointer_t'(ALMOST_FULL));

    // Registered ready, so it follows the fill level one cycle late.
    // The margin below capacity covers the beat accepted in that cycle and
    // the beat still waiting in the capture register.
    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_tready <= 1'b0;
        end
        else begin
            rx_tready <= !almost_full;
        end
    end
endmodule

`default_nettype wire

// File: gray_pointer_sync.sv
/*
 * Gray pointer synchronizer.
 * Two flop stages in the destination clock domain bring a Gray-coded FIFO
 * pointer across from the other domain.
 */
`timescale 1ns/1ps
`default_nettype none

module gray_pointer_sync (
    input logic areset_n,
    input logic clk,
    input cdc_fifo_pkg::pointer_t pointer,
    output cdc_fifo_pkg::pointer_t pointer_synced
);
    import cdc_fifo_pkg::*;

    // First stage may go metastable.
    // Only one bit of the pointer moves per step, so whichever value it
    // settles to is either the old or the new pointer.
    pointer_t pointer_stage;

    always_ff @(posedge clk or negedge areset_n) begin
        if (!areset_n) begin
            pointer_stage <= '0;
        end
        else begin
            pointer_stage <= pointer;
        end
    end

    // Second stage gives the first a full cycle to settle.
    always_ff @(posedge clk or negedge areset_n) begin
        if (!areset_n) begin
            pointer_synced <= '0;
        end
        else begin
            pointer_synced <= pointer_stage;
        end
    end
endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator, then judge the log.
rm -f sim.log
verilator --binary --timing --top-module cdc_fifo_tb -f cdc_fifo.f \
    && (./obj_dir/Vcdc_fifo_tb 2>&1 | tee sim.log) \
    && ! grep -q "Result: FAILED" sim.log \
    && grep -q "Result: PASSED" sim.log \
    || { echo "Simulation did not pass"; exit 1; }
